/* fetch_pkg.sv */
package fetch_pkg;

	// One 64-bit memory beat, seen whole or as two instruction words
	typedef union packed {
		logic [63:0]      dword;
		logic [1:0][31:0] word;          // word[1] is the upper half
	} mem_beat_u;

	typedef struct packed {
		logic [31:0] addr;
	} cache_req_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;               // Bit 1 set on a miss
	} cache_rsp_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [7:0]  strb;
	} cache_fill_t;

	localparam logic [1:0] RESP_HIT  = 2'b00;
	localparam logic [1:0] RESP_MISS = 2'b10;

	localparam logic [1:0] MEM_OKAY  = 2'b00;   // Bus read status for a good beat
	localparam logic [7:0] FILL_STRB = 8'hff;   // Full-line instruction fill

endpackage

/* ifu.sv */
module ifu import fetch_pkg::*; #(
	parameter logic [31:0] SRAM_BASE = 32'h0f000000,
	parameter logic [31:0] SRAM_SIZE = 32'h00002000
) (
	input  logic        clock,
	input  logic        reset,
	input  logic        wb_valid,
	input  logic [31:0] pc,
	output logic [31:0] inst,
	output logic        ifu_aligned,
	output logic        idu_valid,

	output logic        cache_ar_valid,
	output cache_req_t  cache_ar,
	input  logic        cache_ar_ready,
	input  logic        cache_r_valid,
	input  cache_rsp_t  cache_r,
	output logic        cache_r_ready,

	output logic        cache_aw_valid,
	output logic        cache_w_valid,
	output cache_fill_t cache_fill,
	input  logic        cache_aw_ready,
	input  logic        cache_w_ready,
	input  logic        cache_b_valid,
	output logic        cache_b_ready,

	output logic        mem_ar_valid,
	output logic [31:0] mem_araddr,
	input  logic        mem_ar_ready,
	input  logic        mem_r_valid,
	input  mem_beat_u   mem_rdata,
	input  logic [1:0]  mem_rresp,
	output logic        mem_r_ready
);

	logic        in_sram;
	logic        busy;
	logic        accept;
	logic        rsp_fire;
	logic        rsp_hit;
	logic        rsp_miss;
	logic        beat_fire;
	logic        fill_done;
	logic        fetch_done;
	logic [31:0] beat_word;
	logic [7:0]  fill_strb;

	assign in_sram     = (pc - SRAM_BASE) < SRAM_SIZE;   // Unsigned window check
	assign ifu_aligned = in_sram;

	assign cache_r_ready = 1'b1;
	assign cache_b_ready = 1'b1;
	assign mem_r_ready   = 1'b1;

	assign cache_ar   = '{addr: pc};
	assign mem_araddr = pc;
	assign cache_fill = '{addr: pc, data: inst, strb: fill_strb};

	assign accept     = wb_valid & ~busy;
	assign rsp_fire   = cache_r_valid & cache_r_ready;
	assign rsp_hit    = rsp_fire & ~cache_r.resp[1];
	assign rsp_miss   = rsp_fire & cache_r.resp[1];
	assign beat_fire  = mem_r_valid & mem_r_ready;
	assign fill_done  = cache_b_valid & cache_b_ready;
	assign fetch_done = rsp_hit | fill_done | (beat_fire & in_sram);

	// SRAM beats carry two words, pc[2] picks one
	assign beat_word = in_sram ? mem_rdata.word[pc[2]] : mem_rdata.dword[31:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			busy           <= 1'b1;   // Reset pc fetch in flight
			cache_ar_valid <= 1'b1;
			cache_aw_valid <= 1'b0;
			cache_w_valid  <= 1'b0;
			mem_ar_valid   <= 1'b0;
			idu_valid      <= 1'b0;
		end else begin
			busy           <= (busy & ~fetch_done) | accept;
			cache_ar_valid <= (cache_ar_valid & ~cache_ar_ready) | (accept & ~in_sram);
			cache_aw_valid <= (cache_aw_valid & ~cache_aw_ready) | rsp_miss;
			cache_w_valid  <= (cache_w_valid & ~cache_w_ready) | (beat_fire & ~in_sram);
			mem_ar_valid   <= (mem_ar_valid & ~mem_ar_ready) | rsp_miss
				| (accept & in_sram);
			idu_valid      <= fetch_done;
		end
	end

	always_ff @(posedge clock) begin
		if (rsp_hit) begin
			inst <= cache_r.data;
		end else if (beat_fire) begin
			inst <= beat_word;
		end
	end

	// A bad beat still reaches decode but is not cached
	always_ff @(posedge clock) begin
		if (beat_fire) begin
			fill_strb <= (mem_rresp == MEM_OKAY) ? FILL_STRB : 8'h00;
		end
	end

endmodule

/* icache.sv */
module icache import fetch_pkg::*; #(
	parameter int ICACHE_LINES = 16
) (
	input  logic        clock,
	input  logic        reset,

	input  logic        cache_ar_valid,
	input  cache_req_t  cache_ar,
	output logic        cache_ar_ready,
	output logic        cache_r_valid,
	output cache_rsp_t  cache_r,
	input  logic        cache_r_ready,

	input  logic        cache_aw_valid,
	input  logic        cache_w_valid,
	input  cache_fill_t cache_fill,
	output logic        cache_aw_ready,
	output logic        cache_w_ready,
	output logic        cache_b_valid,
	input  logic        cache_b_ready
);

	localparam int INDEX_W = $clog2(ICACHE_LINES);
	localparam int TAG_W   = 30 - INDEX_W;

	logic [TAG_W-1:0]        tag_mem  [ICACHE_LINES];
	logic [31:0]             data_mem [ICACHE_LINES];
	logic [ICACHE_LINES-1:0] line_valid;

	logic                    ar_fire;
	logic [INDEX_W-1:0]      rd_index;
	logic [TAG_W-1:0]        rd_tag;
	logic                    rd_hit;

	logic                    aw_fire;
	logic                    w_fire;
	logic                    aw_held;
	logic                    w_held;
	logic [31:0]             aw_addr_q;
	logic [31:0]             w_data_q;
	logic [7:0]              w_strb_q;
	logic [31:0]             wr_addr;
	logic [31:0]             wr_data;
	logic [7:0]              wr_strb;
	logic                    wr_go;
	logic                    wr_en;
	logic [INDEX_W-1:0]      wr_index;
	logic [TAG_W-1:0]        wr_tag;

	assign cache_ar_ready = 1'b1;
	assign cache_aw_ready = 1'b1;
	assign cache_w_ready  = 1'b1;

	assign ar_fire  = cache_ar_valid & cache_ar_ready;
	assign rd_index = cache_ar.addr[INDEX_W+1:2];
	assign rd_tag   = cache_ar.addr[31:INDEX_W+2];
	assign rd_hit   = line_valid[rd_index] && (tag_mem[rd_index] == rd_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			cache_r_valid <= 1'b0;
		end else begin
			cache_r_valid <= ar_fire | (cache_r_valid & ~cache_r_ready);
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			cache_r.data <= data_mem[rd_index];
			cache_r.resp <= rd_hit ? RESP_HIT : RESP_MISS;
		end
	end

	assign aw_fire = cache_aw_valid & cache_aw_ready;
	assign w_fire  = cache_w_valid & cache_w_ready;

	// Address and data may arrive apart, the held copy wins
	assign wr_addr  = aw_held ? aw_addr_q : cache_fill.addr;
	assign wr_data  = w_held ? w_data_q : cache_fill.data;
	assign wr_strb  = w_held ? w_strb_q : cache_fill.strb;
	assign wr_go    = (aw_held | aw_fire) & (w_held | w_fire);
	assign wr_en    = wr_go & (|wr_strb);
	assign wr_index = wr_addr[INDEX_W+1:2];
	assign wr_tag   = wr_addr[31:INDEX_W+2];

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_held       <= 1'b0;
			w_held        <= 1'b0;
			cache_b_valid <= 1'b0;
			line_valid    <= '0;    // Every first access misses
		end else begin
			aw_held       <= (aw_held | aw_fire) & ~wr_go;
			w_held        <= (w_held | w_fire) & ~wr_go;
			cache_b_valid <= wr_go | (cache_b_valid & ~cache_b_ready);
			if (wr_en) begin
				line_valid[wr_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire) begin
			aw_addr_q <= cache_fill.addr;
		end
		if (w_fire) begin
			w_data_q <= cache_fill.data;
			w_strb_q <= cache_fill.strb;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			tag_mem[wr_index]  <= wr_tag;
			data_mem[wr_index] <= wr_data;
		end
	end

endmodule

/* fetch_top.sv */
module fetch_top import fetch_pkg::*; #(
	parameter logic [31:0] SRAM_BASE    = 32'h0f000000,
	parameter logic [31:0] SRAM_SIZE    = 32'h00002000,
	parameter int          ICACHE_LINES = 16
) (
	input  logic        clock,
	input  logic        reset,
	input  logic        wb_valid,
	input  logic [31:0] pc,
	output logic [31:0] inst,
	output logic        ifu_aligned,
	output logic        idu_valid,

	output logic        mem_ar_valid,
	output logic [31:0] mem_araddr,
	input  logic        mem_ar_ready,
	input  logic        mem_r_valid,
	input  mem_beat_u   mem_rdata,
	input  logic [1:0]  mem_rresp,
	output logic        mem_r_ready
);

	logic        cache_ar_valid;
	cache_req_t  cache_ar;
	logic        cache_ar_ready;
	logic        cache_r_valid;
	cache_rsp_t  cache_r;
	logic        cache_r_ready;
	logic        cache_aw_valid;
	logic        cache_w_valid;
	cache_fill_t cache_fill;
	logic        cache_aw_ready;
	logic        cache_w_ready;
	logic        cache_b_valid;
	logic        cache_b_ready;

	ifu #(
		.SRAM_BASE (SRAM_BASE),
		.SRAM_SIZE (SRAM_SIZE)
	) ifu_inst (
		.clock          (clock),
		.reset          (reset),
		.wb_valid       (wb_valid),
		.pc             (pc),
		.inst           (inst),
		.ifu_aligned    (ifu_aligned),
		.idu_valid      (idu_valid),
		.cache_ar_valid (cache_ar_valid),
		.cache_ar       (cache_ar),
		.cache_ar_ready (cache_ar_ready),
		.cache_r_valid  (cache_r_valid),
		.cache_r        (cache_r),
		.cache_r_ready  (cache_r_ready),
		.cache_aw_valid (cache_aw_valid),
		.cache_w_valid  (cache_w_valid),
		.cache_fill     (cache_fill),
		.cache_aw_ready (cache_aw_ready),
		.cache_w_ready  (cache_w_ready),
		.cache_b_valid  (cache_b_valid),
		.cache_b_ready  (cache_b_ready),
		.mem_ar_valid   (mem_ar_valid),
		.mem_araddr     (mem_araddr),
		.mem_ar_ready   (mem_ar_ready),
		.mem_r_valid    (mem_r_valid),
		.mem_rdata      (mem_rdata),
		.mem_rresp      (mem_rresp),
		.mem_r_ready    (mem_r_ready)
	);

	icache #(
		.ICACHE_LINES (ICACHE_LINES)
	) icache_inst (
		.clock          (clock),
		.reset          (reset),
		.cache_ar_valid (cache_ar_valid),
		.cache_ar       (cache_ar),
		.cache_ar_ready (cache_ar_ready),
		.cache_r_valid  (cache_r_valid),
		.cache_r        (cache_r),
		.cache_r_ready  (cache_r_ready),
		.cache_aw_valid (cache_aw_valid),
		.cache_w_valid  (cache_w_valid),
		.cache_fill     (cache_fill),
		.cache_aw_ready (cache_aw_ready),
		.cache_w_ready  (cache_w_ready),
		.cache_b_valid  (cache_b_valid),
		.cache_b_ready  (cache_b_ready)
	);

endmodule

/* fetch_sva.sv */
module fetch_sva #(
	parameter logic [31:0] SRAM_BASE = 32'h0f000000,
	parameter logic [31:0] SRAM_SIZE = 32'h00002000
) (
	input logic        clock,
	input logic        reset,
	input logic [31:0] pc,
	input logic [31:0] inst,
	input logic        ifu_aligned,
	input logic        idu_valid,
	input logic        mem_ar_valid,
	input logic [31:0] mem_araddr,
	input logic        mem_ar_ready,
	input logic        mem_r_valid,
	input logic        mem_r_ready
);

	int unsigned fail_count = 0;

	// Memory content is the word address with its upper half inverted
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return {~addr[31:16], addr[15:2], 2'b00};
	endfunction

	function automatic logic in_window(input logic [31:0] addr);
		return (addr >= SRAM_BASE) && (addr < SRAM_BASE + SRAM_SIZE);
	endfunction

	reset_outputs: assert property (@(posedge clock) $fell(reset) |-> !mem_ar_valid && !idu_valid)
		else begin
			fail_count++;
			$error("mem_ar_valid or idu_valid was high in the first cycle after reset");
		end

	inst_value: assert property (@(posedge clock) disable iff (reset)
		idu_valid |-> inst == expected_word(pc))
		else begin
			fail_count++;
			$error("FAILED inst: expected %h, got %h",
				expected_word($sampled(pc)), $sampled(inst));
		end

	aligned_path: assert property (@(posedge clock) disable iff (reset)
		idu_valid |-> ifu_aligned == in_window(pc))
		else begin
			fail_count++;
			$error("FAILED ifu_aligned: expected %h, got %h",
				in_window($sampled(pc)), $sampled(ifu_aligned));
		end

	request_hold: assert property (@(posedge clock) disable iff (reset)
		mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_araddr))
		else begin
			fail_count++;
			$error("mem_ar_valid or mem_araddr changed before mem_ar_ready");
		end

	beat_taken: assert property (@(posedge clock) disable iff (reset)
		mem_r_valid |-> mem_r_ready)
		else begin
			fail_count++;
			$error("mem_r_ready was low while a memory beat was offered");
		end

	single_pulse: assert property (@(posedge clock) disable iff (reset)
		idu_valid |=> !idu_valid)
		else begin
			fail_count++;
			$error("idu_valid stayed high for two cycles");
		end

endmodule

bind fetch_top fetch_sva #(
	.SRAM_BASE (SRAM_BASE),
	.SRAM_SIZE (SRAM_SIZE)
) fetch_sva_inst (
	.clock        (clock),
	.reset        (reset),
	.pc           (pc),
	.inst         (inst),
	.ifu_aligned  (ifu_aligned),
	.idu_valid    (idu_valid),
	.mem_ar_valid (mem_ar_valid),
	.mem_araddr   (mem_araddr),
	.mem_ar_ready (mem_ar_ready),
	.mem_r_valid  (mem_r_valid),
	.mem_r_ready  (mem_r_ready)
);

/* fetch_tb.sv */
module fetch_tb import fetch_pkg::*; ();

	localparam int          ICACHE_LINES = 16;
	localparam int          RESET_CYCLES = 10;
	localparam int          NUM_CASES    = 14;
	localparam int          NUM_FETCHES  = NUM_CASES + 1;   // Plus the reset pc fetch
	localparam int          HIT_LATENCY  = 3;
	localparam int          LIMIT        = NUM_FETCHES * 20 + 50;
	localparam logic [31:0] RESET_PC     = 32'h00001000;
	localparam logic [31:0] CONFLICT     = ICACHE_LINES * 4;

	typedef struct packed {
		logic [31:0] pc;
		logic [1:0]  requests;   // Expected memory requests
		logic        hit;
	} fetch_case_t;

	logic        clock;
	logic        reset;
	logic        wb_valid;
	logic [31:0] pc;
	logic [31:0] inst;
	logic        ifu_aligned;
	logic        idu_valid;
	logic        mem_ar_valid;
	logic [31:0] mem_araddr;
	logic        mem_ar_ready;
	logic        mem_r_valid;
	mem_beat_u   mem_rdata;
	logic [1:0]  mem_rresp;
	logic        mem_r_ready;

	fetch_case_t cases [NUM_CASES];
	int unsigned errors;
	int unsigned mem_requests;
	int unsigned idu_pulses;
	logic [31:0] last_pc;
	logic [31:0] last_inst;

	fetch_top fetch_top_inst (
		.clock        (clock),
		.reset        (reset),
		.wb_valid     (wb_valid),
		.pc           (pc),
		.inst         (inst),
		.ifu_aligned  (ifu_aligned),
		.idu_valid    (idu_valid),
		.mem_ar_valid (mem_ar_valid),
		.mem_araddr   (mem_araddr),
		.mem_ar_ready (mem_ar_ready),
		.mem_r_valid  (mem_r_valid),
		.mem_rdata    (mem_rdata),
		.mem_rresp    (mem_rresp),
		.mem_r_ready  (mem_r_ready)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] model_word(input logic [31:0] addr);
		return {~addr[31:16], addr[15:2], 2'b00};
	endfunction

	function automatic mem_beat_u make_beat(input logic [31:0] addr);
		mem_beat_u beat;
		beat.word[0] = model_word({addr[31:3], 3'b000});
		beat.word[1] = model_word({addr[31:3], 3'b100});
		return beat;
	endfunction

	task automatic load_cases();
		cases[0]  = '{pc: RESET_PC, requests: 2'd0, hit: 1'b1};
		cases[1]  = '{pc: 32'h00002008, requests: 2'd1, hit: 1'b0};
		cases[2]  = '{pc: 32'h00002008, requests: 2'd0, hit: 1'b1};
		cases[3]  = '{pc: 32'h0f000010, requests: 2'd1, hit: 1'b0};   // SRAM lower word
		cases[4]  = '{pc: 32'h0f000014, requests: 2'd1, hit: 1'b0};   // SRAM upper word
		cases[5]  = '{pc: 32'h0f000014, requests: 2'd1, hit: 1'b0};
		cases[6]  = '{pc: 32'h00003000, requests: 2'd1, hit: 1'b0};
		cases[7]  = '{pc: 32'h00003000 + CONFLICT, requests: 2'd1, hit: 1'b0};
		cases[8]  = '{pc: 32'h00003000, requests: 2'd1, hit: 1'b0};
		cases[9]  = '{pc: 32'h00003000 + CONFLICT, requests: 2'd1, hit: 1'b0};
		cases[10] = '{pc: 32'h0f001ffc, requests: 2'd1, hit: 1'b0};   // Last SRAM word
		cases[11] = '{pc: 32'h0f002000, requests: 2'd1, hit: 1'b0};   // Just past the window
		cases[12] = '{pc: 32'h0f002000, requests: 2'd0, hit: 1'b1};
		cases[13] = '{pc: 32'h00002008, requests: 2'd0, hit: 1'b1};   // Line 2 survived
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic run_fetch(input fetch_case_t fc);
		int unsigned start;
		int unsigned latency;
		start = mem_requests;
		@(posedge clock);
		wb_valid <= 1'b1;
		pc       <= fc.pc;
		@(posedge clock);
		wb_valid <= 1'b0;
		latency = 0;
		while (!idu_valid) begin
			@(posedge clock);
			latency++;
		end
		check_value("mem requests", fc.requests, mem_requests - start);
		if (fc.hit) begin
			check_value("hit latency", HIT_LATENCY, latency);
		end
		if (fc.pc == last_pc) begin
			check_value("inst", last_inst, inst);
		end
		last_pc   = fc.pc;
		last_inst = inst;
	endtask

	// Memory bus model
	initial begin : memory_model
		int unsigned stall;
		int unsigned delay;
		logic [31:0] addr;
		void'($urandom(32'ha4f));
		forever begin
			@(posedge clock);
			if (!reset && mem_ar_valid) begin
				stall = $urandom_range(3, 0);
				repeat (stall) @(posedge clock);
				mem_ar_ready <= 1'b1;
				@(posedge clock);   // Address accepted here
				addr = mem_araddr;
				mem_ar_ready <= 1'b0;
				delay = $urandom_range(4, 1);
				repeat (delay - 1) @(posedge clock);
				mem_rdata   <= make_beat(addr);
				mem_r_valid <= 1'b1;
				@(posedge clock);
				mem_r_valid <= 1'b0;
			end
		end
	end

	always @(posedge clock) begin
		if (!reset && mem_ar_valid && mem_ar_ready) begin
			mem_requests++;
		end
		if (!reset && idu_valid) begin
			idu_pulses++;
		end
	end

	initial begin : watchdog
		repeat (LIMIT) @(posedge clock);
		$display("Timeout: the fetch sequence did not finish within %0d cycles", LIMIT);
		$display("Simulation failed");
		$finish;
	end

	initial begin : stimulus
		int unsigned start;
		int unsigned sva_errors;
		errors       = 0;
		mem_requests = 0;
		idu_pulses   = 0;
		reset        <= 1'b1;
		wb_valid     <= 1'b0;
		pc           <= RESET_PC;
		mem_ar_ready <= 1'b0;
		mem_r_valid  <= 1'b0;
		mem_rdata    <= '0;
		mem_rresp    <= MEM_OKAY;
		load_cases();
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		start = mem_requests;
		@(posedge clock);
		while (!idu_valid) begin
			@(posedge clock);   // Reset pc needs no wb_valid
		end
		check_value("mem requests", 1, mem_requests - start);
		last_pc   = RESET_PC;
		last_inst = inst;
		for (int i = 0; i < NUM_CASES; i++) begin
			run_fetch(cases[i]);
		end
		repeat (3) @(posedge clock);
		check_value("idu_valid pulses", NUM_FETCHES, idu_pulses);
		sva_errors = fetch_top_inst.fetch_sva_inst.fail_count;
		$display("Done: %0d testbench errors, %0d assertion failures", errors, sva_errors);
		if (errors == 0 && sva_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
fetch_pkg.sv
ifu.sv
icache.sv
fetch_top.sv
fetch_sva.sv
fetch_tb.sv

/* Bender.yml */
package:
  name: fetch

sources:
  - fetch_pkg.sv
  - ifu.sv
  - icache.sv
  - fetch_top.sv
  - target: test
    files:
      - fetch_sva.sv
      - fetch_tb.sv
